// File: sdmac_settings.svh
// FIFO depth and data widths for the SCSI DMA engine, included by every file that sizes storage
`ifndef SDMAC_SETTINGS_SVH
`define SDMAC_SETTINGS_SVH

// Longword entries in the FIFO (a power of two)
`define SDMAC_FIFO_DEPTH 8

// Width of next-in / next-out pointers
`define SDMAC_PTR_W $clog2(`SDMAC_FIFO_DEPTH)

`define SDMAC_LW_W   32 // Host longword
`define SDMAC_BYTE_W 8  // SCSI chip data bus

`endif

// File: sdmac_pkg.sv
// State and direction types shared by the SCSI DMA engine blocks, referenced by scoped name
package sdmac_pkg;

    // Sequencer states with fixed encodings
    typedef enum logic [4:0] {
        IDLE_DMA_RD = 5'd0,
        CPUREQ      = 5'd8,
        IDLE_DMA_WR = 5'd16,
        C2S_1       = 5'd17,
        C2S_2       = 5'd26,
        C2S_3       = 5'd6,
        C2S_4       = 5'd22,
        C2S_5       = 5'd14,
        F2S_1       = 5'd28,
        F2S_2       = 5'd2,
        F2S_3       = 5'd18,
        F2S_4       = 5'd1,
        S2C_1       = 5'd10,
        S2C_2       = 5'd30,
        S2C_3       = 5'd3,
        S2C_4       = 5'd19,
        S2C_5       = 5'd9,
        S2C_6       = 5'd25,
        S2F_1       = 5'd24,
        S2F_2       = 5'd4,
        S2F_3       = 5'd20,
        S2F_4       = 5'd12
    } scsi_state_t;

    typedef enum logic {
        DIR_TO_SCSI   = 1'b0, // Host fills FIFO, chip drains it
        DIR_FROM_SCSI = 1'b1  // Chip fills FIFO, host drains it
    } xfer_dir_t;

    // CPU register cycle tracking
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_BUSY,
        PORT_ACK,
        PORT_DROP
    } cpu_port_state_t;

endpackage

// File: scsi_sm.sv
// Control sequencer arbitrating CPU register cycles and DMA bytes, drives chip strobes and FIFO steps
module scsi_sm (
    input  logic                  CLK,
    input  logic                  nRESET,
    input  logic                  bo_eq3,      // Byte pointer on last lane
    input  logic                  cpu_creq,    // CPU register cycle pending
    input  logic                  scsi_drq_n,  // DMA request from chip
    input  logic                  cpu_dsack_n, // Low while CPU cycle terminates
    input  sdmac_pkg::xfer_dir_t  dma_dir,
    input  logic                  fifo_empty,
    input  logic                  fifo_full,
    input  logic                  ri_pend,     // Counter increment in progress
    input  logic                  rd_pend,     // Counter decrement in progress
    input  logic                  cpu_rw,      // 1 = read
    output logic                  cpu2s,
    output logic                  scsi_dack,
    output logic                  f2s,
    output logic                  inc_bo,
    output logic                  inc_ni,
    output logic                  inc_no,
    output logic                  rd_req,
    output logic                  scsi_re,
    output logic                  ri_req,
    output logic                  s2cpu,
    output logic                  s2f,
    output logic                  scsi_cs,
    output logic                  scsi_we,
    output logic                  set_dsack
);

    sdmac_pkg::scsi_state_t state;

    logic dir_from;
    logic start_s2f;
    logic start_f2s;

    assign dir_from = (dma_dir == sdmac_pkg::DIR_FROM_SCSI);

    // A pending CPU cycle always blocks a new DMA byte
    assign start_s2f = !scsi_drq_n && !fifo_full && dir_from && !cpu_creq && !ri_pend;
    assign start_f2s = !scsi_drq_n && !fifo_empty && !dir_from && !cpu_creq && !rd_pend;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= sdmac_pkg::IDLE_DMA_RD;
        end else begin
            case (state)
                sdmac_pkg::IDLE_DMA_RD: begin
                    if (start_s2f)
                        state <= sdmac_pkg::S2F_1;
                    else if (cpu_creq)
                        state <= sdmac_pkg::CPUREQ;
                    else if (!dir_from)
                        state <= sdmac_pkg::IDLE_DMA_WR; // Direction flipped to host-to-chip
                end
                sdmac_pkg::IDLE_DMA_WR: begin
                    if (start_f2s)
                        state <= sdmac_pkg::F2S_1;
                    else if (cpu_creq)
                        state <= sdmac_pkg::CPUREQ;
                    else if (dir_from)
                        state <= sdmac_pkg::IDLE_DMA_RD;
                end
                sdmac_pkg::CPUREQ: state <= cpu_rw ? sdmac_pkg::S2C_1 : sdmac_pkg::C2S_1;

                sdmac_pkg::C2S_1: state <= sdmac_pkg::C2S_2;
                sdmac_pkg::C2S_2: state <= sdmac_pkg::C2S_3;
                sdmac_pkg::C2S_3: state <= sdmac_pkg::C2S_4;
                sdmac_pkg::C2S_4: state <= sdmac_pkg::C2S_5;
                sdmac_pkg::C2S_5: state <= cpu_dsack_n ? sdmac_pkg::IDLE_DMA_RD : sdmac_pkg::C2S_5;

                sdmac_pkg::S2C_1: state <= sdmac_pkg::S2C_2;
                sdmac_pkg::S2C_2: state <= sdmac_pkg::S2C_3;
                sdmac_pkg::S2C_3: state <= sdmac_pkg::S2C_4;
                sdmac_pkg::S2C_4: state <= sdmac_pkg::S2C_5;
                sdmac_pkg::S2C_5: state <= sdmac_pkg::S2C_6;
                sdmac_pkg::S2C_6: state <= cpu_dsack_n ? sdmac_pkg::IDLE_DMA_RD : sdmac_pkg::S2C_6;

                sdmac_pkg::F2S_1: state <= sdmac_pkg::F2S_2;
                sdmac_pkg::F2S_2: state <= sdmac_pkg::F2S_3;
                sdmac_pkg::F2S_3: state <= sdmac_pkg::F2S_4;
                sdmac_pkg::F2S_4: state <= sdmac_pkg::IDLE_DMA_WR;

                sdmac_pkg::S2F_1: state <= sdmac_pkg::S2F_2;
                sdmac_pkg::S2F_2: state <= sdmac_pkg::S2F_3;
                sdmac_pkg::S2F_3: state <= sdmac_pkg::S2F_4;
                sdmac_pkg::S2F_4: state <= sdmac_pkg::IDLE_DMA_RD;
                default:          state <= sdmac_pkg::IDLE_DMA_RD;
            endcase
        end
    end

    // Moore outputs, plus the Mealy start strobes from the idle states
    always_comb begin
        cpu2s     = 1'b0;
        scsi_dack = 1'b0;
        f2s       = 1'b0;
        inc_bo    = 1'b0;
        inc_ni    = 1'b0;
        inc_no    = 1'b0;
        rd_req    = 1'b0;
        scsi_re   = 1'b0;
        ri_req    = 1'b0;
        s2cpu     = 1'b0;
        s2f       = 1'b0;
        scsi_cs   = 1'b0;
        scsi_we   = 1'b0;
        set_dsack = 1'b0;
        case (state)
            sdmac_pkg::IDLE_DMA_RD: begin
                scsi_dack = start_s2f;
                scsi_re   = start_s2f;
                s2f       = start_s2f;
            end
            sdmac_pkg::IDLE_DMA_WR: begin
                scsi_dack = start_f2s;
                scsi_we   = start_f2s;
                f2s       = start_f2s;
            end
            sdmac_pkg::CPUREQ: begin
                scsi_cs = 1'b1;
                scsi_re = cpu_rw;
                s2cpu   = cpu_rw;
                scsi_we = !cpu_rw;
                cpu2s   = !cpu_rw;
            end
            sdmac_pkg::C2S_1, sdmac_pkg::C2S_2: begin
                scsi_cs = 1'b1;
                cpu2s   = 1'b1;
                scsi_we = 1'b1;
            end
            sdmac_pkg::C2S_3: begin
                scsi_cs   = 1'b1;
                cpu2s     = 1'b1;
                set_dsack = 1'b1; // Write strobe already released
            end
            sdmac_pkg::S2C_1, sdmac_pkg::S2C_2, sdmac_pkg::S2C_3: begin
                scsi_cs = 1'b1;
                scsi_re = 1'b1;
                s2cpu   = 1'b1;
            end
            sdmac_pkg::S2C_4: begin
                scsi_cs   = 1'b1;
                scsi_re   = 1'b1;
                s2cpu     = 1'b1;
                set_dsack = 1'b1;
            end
            sdmac_pkg::S2C_5, sdmac_pkg::S2C_6: s2cpu = 1'b1;
            sdmac_pkg::F2S_1: begin
                scsi_dack = 1'b1;
                scsi_we   = 1'b1;
                f2s       = 1'b1;
            end
            sdmac_pkg::F2S_2: f2s = 1'b1;
            sdmac_pkg::F2S_3: begin
                f2s    = 1'b1;
                inc_bo = 1'b1;
                inc_no = bo_eq3; // Longword fully sent
                rd_req = bo_eq3;
            end
            sdmac_pkg::S2F_1: begin
                scsi_dack = 1'b1;
                scsi_re   = 1'b1;
                s2f       = 1'b1;
            end
            sdmac_pkg::S2F_2: s2f = 1'b1;
            sdmac_pkg::S2F_3: begin
                s2f    = 1'b1;
                inc_bo = 1'b1;
                inc_ni = bo_eq3; // Longword fully packed
                ri_req = bo_eq3;
            end
            default: ;
        endcase
    end

endmodule

// File: dma_fifo.sv
// Longword FIFO with byte lane access for the chip side and a four-phase longword port for the host
`include "sdmac_settings.svh"

module dma_fifo (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  sdmac_pkg::xfer_dir_t     dma_dir,
    input  logic                     inc_bo,
    input  logic                     inc_ni,
    input  logic                     inc_no,
    input  logic                     ri_req,
    input  logic                     rd_req,
    input  logic [`SDMAC_BYTE_W-1:0] s2f_byte,
    input  logic                     host_req,
    input  logic [`SDMAC_LW_W-1:0]   host_wdata,
    output logic                     bo_eq3,
    output logic                     fifo_empty,
    output logic                     fifo_full,
    output logic                     ri_pend,
    output logic                     rd_pend,
    output logic [`SDMAC_BYTE_W-1:0] f2s_byte,
    output logic                     host_ack,
    output logic [`SDMAC_LW_W-1:0]   host_rdata
);

    localparam logic [`SDMAC_PTR_W:0] FULL_CNT = `SDMAC_FIFO_DEPTH;

    logic [`SDMAC_LW_W-1:0]  mem [`SDMAC_FIFO_DEPTH];
    logic [1:0]              bo;    // Byte pointer (0 selects bits 31..24)
    logic [`SDMAC_PTR_W-1:0] ni;
    logic [`SDMAC_PTR_W-1:0] no;
    logic [`SDMAC_PTR_W:0]   count; // Whole longwords held

    logic dir_from;
    logic host_ok;
    logic host_take;
    logic host_pop;
    logic host_push;
    logic cnt_up;
    logic cnt_dn;

    assign dir_from   = (dma_dir == sdmac_pkg::DIR_FROM_SCSI);
    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == FULL_CNT);
    assign bo_eq3     = (bo == 2'd3);

    // Big-endian lane select
    assign f2s_byte = mem[no][`SDMAC_LW_W - 1 - bo * `SDMAC_BYTE_W -: `SDMAC_BYTE_W];

    // Host waits while a chip-side counter change is still in flight
    assign host_ok   = dir_from ? (!fifo_empty && !rd_pend) : (!fifo_full && !ri_pend);
    assign host_take = host_req && !host_ack && host_ok;
    assign host_pop  = host_take && dir_from;
    assign host_push = host_take && !dir_from;

    assign cnt_up = ri_pend || host_push;
    assign cnt_dn = rd_pend || host_pop;

    always_ff @(posedge CLK) begin
        if (inc_bo && dir_from)
            mem[ni][`SDMAC_LW_W - 1 - bo * `SDMAC_BYTE_W -: `SDMAC_BYTE_W] <= s2f_byte;
        if (host_push)
            mem[ni] <= host_wdata;
        if (host_pop)
            host_rdata <= mem[no]; // Held while ack is high
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            bo       <= '0;
            ni       <= '0;
            no       <= '0;
            count    <= '0;
            ri_pend  <= 1'b0;
            rd_pend  <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            ri_pend <= ri_req;
            rd_pend <= rd_req;
            if (inc_bo)
                bo <= bo + 2'd1;
            if (inc_ni || host_push)
                ni <= ni + 1'b1;
            if (inc_no || host_pop)
                no <= no + 1'b1;
            if (cnt_up && !cnt_dn)
                count <= count + 1'b1;
            else if (cnt_dn && !cnt_up)
                count <= count - 1'b1;
            if (host_take)
                host_ack <= 1'b1;
            else if (!host_req)
                host_ack <= 1'b0;
        end
    end

endmodule

// File: scsi_data_path.sv
// Byte steering between the chip data bus, the CPU port and the FIFO lanes
`include "sdmac_settings.svh"

module scsi_data_path (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic [`SDMAC_BYTE_W-1:0] scsi_din,
    input  logic [`SDMAC_BYTE_W-1:0] cpu_wdata,
    input  logic [`SDMAC_BYTE_W-1:0] f2s_byte,
    input  logic                     cpu2s,
    input  logic                     f2s,
    input  logic                     s2f,
    input  logic                     s2cpu,
    input  logic                     scsi_re,
    output logic [`SDMAC_BYTE_W-1:0] scsi_dout,
    output logic [`SDMAC_BYTE_W-1:0] s2f_byte,
    output logic [`SDMAC_BYTE_W-1:0] cpu_rbyte
);

    logic [`SDMAC_BYTE_W-1:0] rd_cap; // Last byte seen on a chip read strobe

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET)
            rd_cap <= '0;
        else if (scsi_re)
            rd_cap <= scsi_din;
    end

    // CPU write data takes priority over FIFO bytes
    always_comb begin
        if (cpu2s)
            scsi_dout = cpu_wdata;
        else if (f2s)
            scsi_dout = f2s_byte;
        else
            scsi_dout = '0;
    end

    assign s2f_byte  = s2f ? rd_cap : '0;
    assign cpu_rbyte = s2cpu ? rd_cap : '0;

endmodule

// File: cpu_scsi_port.sv
// Four-phase CPU handshake for chip register cycles, terminates each cycle once the sequencer is done
`include "sdmac_settings.svh"

module cpu_scsi_port (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     cpu_req,
    input  logic                     set_dsack,
    input  logic                     s2cpu,
    input  logic [`SDMAC_BYTE_W-1:0] cpu_rbyte,
    output logic                     cpu_creq,
    output logic                     cpu_dsack_n,
    output logic                     cpu_ack,
    output logic [`SDMAC_BYTE_W-1:0] cpu_rdata
);

    sdmac_pkg::cpu_port_state_t state;

    // Request seen straight away in idle so the sequencer can start next edge
    assign cpu_creq = (state == sdmac_pkg::PORT_BUSY) ||
                      (state == sdmac_pkg::PORT_IDLE && cpu_req);

    assign cpu_ack     = (state == sdmac_pkg::PORT_ACK);
    assign cpu_dsack_n = (state != sdmac_pkg::PORT_ACK);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= sdmac_pkg::PORT_IDLE;
        end else begin
            case (state)
                sdmac_pkg::PORT_IDLE: if (cpu_req) state <= sdmac_pkg::PORT_BUSY;
                sdmac_pkg::PORT_BUSY: if (set_dsack) state <= sdmac_pkg::PORT_ACK;
                sdmac_pkg::PORT_ACK:  if (!cpu_req) state <= sdmac_pkg::PORT_DROP; // Release
                default:              state <= sdmac_pkg::PORT_IDLE;
            endcase
        end
    end

    // Read byte latched as the cycle terminates
    always_ff @(posedge CLK) begin
        if (set_dsack && s2cpu)
            cpu_rdata <= cpu_rbyte;
    end

endmodule

// File: scsi_dma_top.sv
// Top level of the SCSI DMA engine, connects the sequencer, FIFO, data path and CPU port
`include "sdmac_settings.svh"

module scsi_dma_top (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  sdmac_pkg::xfer_dir_t     dma_dir,
    input  logic                     cpu_req,
    input  logic                     cpu_rw,
    input  logic [3:0]               cpu_addr,
    input  logic [`SDMAC_BYTE_W-1:0] cpu_wdata,
    input  logic                     host_req,
    input  logic [`SDMAC_LW_W-1:0]   host_wdata,
    input  logic                     scsi_drq_n,
    input  logic [`SDMAC_BYTE_W-1:0] scsi_din,
    output logic                     cpu_ack,
    output logic [`SDMAC_BYTE_W-1:0] cpu_rdata,
    output logic                     host_ack,
    output logic [`SDMAC_LW_W-1:0]   host_rdata,
    output logic                     scsi_cs,
    output logic                     scsi_re,
    output logic                     scsi_we,
    output logic                     scsi_dack,
    output logic [3:0]               scsi_addr,
    output logic [`SDMAC_BYTE_W-1:0] scsi_dout,
    output logic                     fifo_empty,
    output logic                     fifo_full
);

    logic bo_eq3, cpu_creq, cpu_dsack_n, ri_pend, rd_pend;
    logic cpu2s, f2s, s2f, s2cpu, set_dsack;
    logic inc_bo, inc_ni, inc_no, ri_req, rd_req;
    logic [`SDMAC_BYTE_W-1:0] s2f_byte, f2s_byte, cpu_rbyte;

    assign scsi_addr = cpu_addr; // Register select comes straight from the CPU

    scsi_sm u_sm (
        .CLK, .nRESET, .bo_eq3, .cpu_creq, .scsi_drq_n, .cpu_dsack_n, .dma_dir,
        .fifo_empty, .fifo_full, .ri_pend, .rd_pend, .cpu_rw,
        .cpu2s, .scsi_dack, .f2s, .inc_bo, .inc_ni, .inc_no, .rd_req, .scsi_re,
        .ri_req, .s2cpu, .s2f, .scsi_cs, .scsi_we, .set_dsack
    );

    dma_fifo u_fifo (
        .CLK, .nRESET, .dma_dir, .inc_bo, .inc_ni, .inc_no, .ri_req, .rd_req,
        .s2f_byte, .host_req, .host_wdata, .bo_eq3, .fifo_empty, .fifo_full,
        .ri_pend, .rd_pend, .f2s_byte, .host_ack, .host_rdata
    );

    scsi_data_path u_dp (
        .CLK, .nRESET, .scsi_din, .cpu_wdata, .f2s_byte, .cpu2s, .f2s, .s2f,
        .s2cpu, .scsi_re, .scsi_dout, .s2f_byte, .cpu_rbyte
    );

    cpu_scsi_port u_cpu (
        .CLK, .nRESET, .cpu_req, .set_dsack, .s2cpu, .cpu_rbyte,
        .cpu_creq, .cpu_dsack_n, .cpu_ack, .cpu_rdata
    );

endmodule

// File: tb_scsi_dma.sv
// Directed testbench for the SCSI DMA engine, models the SCSI chip and checks all four transfer paths
`include "sdmac_settings.svh"

module tb_scsi_dma;

    localparam int TMO  = 400; // Cycles allowed for any single wait
    localparam int NREG = 16;
    localparam int LANES = `SDMAC_LW_W / `SDMAC_BYTE_W;

    logic                     CLK;
    logic                     nRESET;
    sdmac_pkg::xfer_dir_t     dma_dir;
    logic                     cpu_req;
    logic                     cpu_rw;
    logic [3:0]               cpu_addr;
    logic [`SDMAC_BYTE_W-1:0] cpu_wdata;
    logic                     host_req;
    logic [`SDMAC_LW_W-1:0]   host_wdata;
    logic                     scsi_drq_n;
    logic [`SDMAC_BYTE_W-1:0] scsi_din;
    logic                     cpu_ack;
    logic [`SDMAC_BYTE_W-1:0] cpu_rdata;
    logic                     host_ack;
    logic [`SDMAC_LW_W-1:0]   host_rdata;
    logic                     scsi_cs;
    logic                     scsi_re;
    logic                     scsi_we;
    logic                     scsi_dack;
    logic [3:0]               scsi_addr;
    logic [`SDMAC_BYTE_W-1:0] scsi_dout;
    logic                     fifo_empty;
    logic                     fifo_full;

    // Chip model state
    logic [`SDMAC_BYTE_W-1:0] chip_regs [NREG];
    logic [`SDMAC_BYTE_W-1:0] exp_regs  [NREG];
    logic [`SDMAC_BYTE_W-1:0] src_q [$]; // Bytes the chip still has to send
    logic [`SDMAC_BYTE_W-1:0] rx_q  [$]; // Bytes the chip has received
    logic [`SDMAC_BYTE_W-1:0] exp_q [$]; // Expected byte stream
    logic [`SDMAC_BYTE_W-1:0] wr_latch;
    logic [`SDMAC_BYTE_W-1:0] drop_byte;
    logic [3:0]               smp_addr;
    logic                     smp_reg_rd;
    logic                     rd_strobe_d;
    logic                     wr_strobe_d;
    int                       rx_want;
    int                       src_taken;
    logic [31:0]              lcg_state;
    int                       error_count;
    int                       check_count;

    scsi_dma_top uut (
        .CLK, .nRESET, .dma_dir, .cpu_req, .cpu_rw, .cpu_addr, .cpu_wdata, .host_req,
        .host_wdata, .scsi_drq_n, .scsi_din, .cpu_ack, .cpu_rdata, .host_ack, .host_rdata,
        .scsi_cs, .scsi_re, .scsi_we, .scsi_dack, .scsi_addr, .scsi_dout, .fifo_empty, .fifo_full
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Chip bus sampled mid-cycle
    always @(negedge CLK) begin
        smp_reg_rd = scsi_cs && scsi_re;
        smp_addr   = scsi_addr;
        if (scsi_cs && scsi_we)
            chip_regs[scsi_addr] = scsi_dout; // Level write strobe
        if (scsi_dack && scsi_we)
            wr_latch = scsi_dout;
        if (wr_strobe_d && !(scsi_dack && scsi_we)) begin // Byte done as the strobe falls
            rx_q.push_back(wr_latch);
            if (rx_want > 0)
                rx_want--;
        end
        if (rd_strobe_d && !(scsi_dack && scsi_re)) begin
            src_taken++;
            if (src_q.size() > 0)
                drop_byte = src_q.pop_front();
        end
        wr_strobe_d = scsi_dack && scsi_we;
        rd_strobe_d = scsi_dack && scsi_re;
    end

    // Chip outputs change just after the clock edge
    always @(posedge CLK) begin
        #1;
        scsi_drq_n <= !(src_q.size() > 0 || rx_want > 0);
        if (smp_reg_rd)
            scsi_din <= chip_regs[smp_addr];
        else if (src_q.size() > 0)
            scsi_din <= src_q[0];
        else
            scsi_din <= '0;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic rand_byte(output logic [`SDMAC_BYTE_W-1:0] b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[23:16];
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        sdmac_pkg::scsi_state_t st;
        st = uut.u_sm.state;
        error_count++;
        $display("Timed out at %0t waiting for %s, sequencer in %s", $time, what, st.name());
        finish_run();
    endtask

    // Delays count the clock edges from the request change to the ack change
    task automatic cpu_cycle(input logic rw, input logic [3:0] addr,
                             input logic [`SDMAC_BYTE_W-1:0] wdata,
                             output logic [`SDMAC_BYTE_W-1:0] rdata, output int delay);
        int n;
        @(posedge CLK);
        #1;
        cpu_rw    = rw;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_req   = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!cpu_ack && n < TMO) begin
            n++;
            @(negedge CLK);
        end
        if (!cpu_ack)
            abort_on_timeout("cpu_ack to rise");
        delay = n;
        rdata = cpu_rdata;
        @(posedge CLK);
        #1;
        cpu_req = 1'b0;
        n = 0;
        @(negedge CLK);
        while (cpu_ack && n < TMO) begin
            n++;
            @(negedge CLK);
        end
        if (cpu_ack)
            abort_on_timeout("cpu_ack to fall");
        check_value("cpu_ack release delay", 1, n);
    endtask

    task automatic cpu_write(input logic [3:0] addr, input logic [`SDMAC_BYTE_W-1:0] data,
                             output int delay);
        logic [`SDMAC_BYTE_W-1:0] unused;
        cpu_cycle(1'b0, addr, data, unused, delay);
    endtask

    task automatic cpu_read(input logic [3:0] addr, output logic [`SDMAC_BYTE_W-1:0] data,
                            output int delay);
        cpu_cycle(1'b1, addr, '0, data, delay);
    endtask

    task automatic host_cycle(input logic [`SDMAC_LW_W-1:0] wdata,
                              output logic [`SDMAC_LW_W-1:0] rdata);
        int n;
        @(posedge CLK);
        #1;
        host_wdata = wdata;
        host_req   = 1'b1;
        n = 0;
        while (!host_ack && n < TMO) begin
            @(negedge CLK);
            n++;
        end
        if (!host_ack)
            abort_on_timeout("host_ack to rise");
        rdata = host_rdata; // Held while ack is high
        @(posedge CLK);
        #1;
        host_req = 1'b0;
        n = 0;
        while (host_ack && n < TMO) begin
            @(negedge CLK);
            n++;
        end
        if (host_ack)
            abort_on_timeout("host_ack to fall");
    endtask

    task automatic host_push(input logic [`SDMAC_LW_W-1:0] data);
        logic [`SDMAC_LW_W-1:0] unused;
        host_cycle(data, unused);
    endtask

    task automatic host_pop(output logic [`SDMAC_LW_W-1:0] data);
        host_cycle('0, data);
    endtask

    // First byte of the stream lands in bits 31..24
    task automatic pop_and_compare(input string name);
        logic [`SDMAC_LW_W-1:0] got;
        logic [`SDMAC_LW_W-1:0] exp;
        int i;
        host_pop(got);
        exp = '0;
        for (i = 0; i < LANES; i++)
            exp = {exp[`SDMAC_LW_W-`SDMAC_BYTE_W-1:0], exp_q.pop_front()};
        check_value(name, exp, got);
    endtask

    task automatic load_source(input int count);
        logic [`SDMAC_BYTE_W-1:0] b;
        int i;
        for (i = 0; i < count; i++) begin
            rand_byte(b);
            src_q.push_back(b);
            exp_q.push_back(b);
        end
    endtask

    task automatic set_dir(input sdmac_pkg::xfer_dir_t dir);
        @(posedge CLK);
        #1;
        dma_dir = dir;
    endtask

    task automatic wait_taken(input int target);
        int n;
        n = 0;
        while (src_taken < target && n < TMO) begin
            @(negedge CLK);
            n++;
        end
        if (src_taken < target)
            abort_on_timeout("the chip to hand over its bytes");
    endtask

    task automatic wait_received(input int target);
        int n;
        n = 0;
        while (rx_q.size() < target && n < TMO) begin
            @(negedge CLK);
            n++;
        end
        if (rx_q.size() < target)
            abort_on_timeout("the chip to receive its bytes");
    endtask

    task automatic wait_fifo_flag(input logic want_full);
        int n;
        n = 0;
        while ((want_full ? !fifo_full : !fifo_empty) && n < TMO) begin
            @(negedge CLK);
            n++;
        end
        if (want_full && !fifo_full)
            abort_on_timeout("fifo_full");
        else if (!want_full && !fifo_empty)
            abort_on_timeout("fifo_empty");
    endtask

    task automatic observe_dack_low(input int cycles);
        int n;
        int seen;
        seen = 0;
        for (n = 0; n < cycles; n++) begin
            @(negedge CLK);
            if (scsi_dack)
                seen++;
        end
        check_value("scsi_dack cycles while full", 0, seen);
    endtask

    task automatic reset_values();
        check_value("cpu_ack", 0, cpu_ack);
        check_value("host_ack", 0, host_ack);
        check_value("scsi_cs", 0, scsi_cs);
        check_value("scsi_re", 0, scsi_re);
        check_value("scsi_we", 0, scsi_we);
        check_value("scsi_dack", 0, scsi_dack);
        check_value("fifo_empty", 1, fifo_empty);
        check_value("fifo_full", 0, fifo_full);
    endtask

    task automatic register_access();
        logic [`SDMAC_BYTE_W-1:0] b;
        int a;
        int d;
        for (a = 0; a < NREG; a += 3) begin
            rand_byte(b);
            exp_regs[a] = b;
            cpu_write(a[3:0], b, d);
            check_value("cpu write req to ack cycles", 5, d);
        end
        for (a = 0; a < NREG; a += 3) begin
            cpu_read(a[3:0], b, d);
            check_value($sformatf("cpu_rdata from reg %0d", a), exp_regs[a], b);
            check_value("cpu read req to ack cycles", 6, d);
        end
        for (a = 0; a < NREG; a++)
            check_value($sformatf("chip_regs[%0d]", a), exp_regs[a], chip_regs[a]);
    endtask

    task automatic chip_to_host_stream();
        int i;
        load_source(4 * LANES);
        for (i = 0; i < 4; i++)
            pop_and_compare("host_rdata from chip stream");
        check_value("fifo_empty after drain", 1, fifo_empty);
        check_value("chip bytes left", 0, src_q.size());
    endtask

    task automatic host_to_chip_stream();
        logic [`SDMAC_BYTE_W-1:0] b;
        logic [`SDMAC_LW_W-1:0]   lw;
        int i;
        int k;
        set_dir(sdmac_pkg::DIR_TO_SCSI);
        rx_q.delete();
        rx_want = 3 * LANES;
        for (i = 0; i < 3; i++) begin
            lw = '0;
            for (k = 0; k < LANES; k++) begin
                rand_byte(b);
                exp_q.push_back(b);
                lw = {lw[`SDMAC_LW_W-`SDMAC_BYTE_W-1:0], b};
            end
            host_push(lw);
        end
        wait_received(3 * LANES);
        for (i = 0; i < 3 * LANES; i++)
            check_value($sformatf("chip byte %0d", i), exp_q.pop_front(), rx_q[i]);
        wait_fifo_flag(1'b0);
    endtask

    task automatic fifo_back_pressure();
        int base;
        int i;
        set_dir(sdmac_pkg::DIR_FROM_SCSI);
        base = src_taken;
        load_source(LANES * `SDMAC_FIFO_DEPTH + 8);
        wait_fifo_flag(1'b1);
        observe_dack_low(20);
        check_value("bytes taken until full", LANES * `SDMAC_FIFO_DEPTH, src_taken - base);
        pop_and_compare("host_rdata at full");
        wait_taken(base + LANES * `SDMAC_FIFO_DEPTH + LANES);
        wait_fifo_flag(1'b1);
        observe_dack_low(20);
        check_value("bytes taken after one drain", LANES * (`SDMAC_FIFO_DEPTH + 1),
                    src_taken - base);
        // Withdraw what the chip still holds
        src_q.delete();
        for (i = 0; i < 8 - LANES; i++)
            drop_byte = exp_q.pop_back();
        for (i = 0; i < `SDMAC_FIFO_DEPTH; i++)
            pop_and_compare("host_rdata while draining");
        check_value("fifo_empty after drain", 1, fifo_empty);
    endtask

    task automatic read_during_stream();
        logic [`SDMAC_BYTE_W-1:0] b;
        int base;
        int d;
        int i;
        base = src_taken;
        load_source(4 * LANES);
        wait_taken(base + 6);
        cpu_read(4'd6, b, d);
        check_value("cpu_rdata during stream", exp_regs[6], b);
        check_value("cpu read delay within 10 cycles", 1, d <= 10);
        for (i = 0; i < 4; i++)
            pop_and_compare("host_rdata around cpu read");
        check_value("bytes taken in stream", 4 * LANES, src_taken - base);
        check_value("fifo_empty after stream", 1, fifo_empty);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        lcg_state   = 32'd71085;
        nRESET      = 1'b0;
        dma_dir     = sdmac_pkg::DIR_FROM_SCSI;
        cpu_req     = 1'b0;
        cpu_rw      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        host_req    = 1'b0;
        host_wdata  = '0;
        scsi_drq_n  = 1'b1;
        scsi_din    = '0;
        rx_want     = 0;
        src_taken   = 0;
        rd_strobe_d = 1'b0;
        wr_strobe_d = 1'b0;
        wr_latch    = '0;
        smp_reg_rd  = 1'b0;
        smp_addr    = '0;
        for (int i = 0; i < NREG; i++) begin
            chip_regs[i] = {i[3:0], ~i[3:0]}; // Power-up contents differ per register
            exp_regs[i]  = {i[3:0], ~i[3:0]};
        end
        repeat (10) @(posedge CLK);
        #1;
        nRESET = 1'b1;
        reset_values();
        register_access();
        chip_to_host_stream();
        host_to_chip_stream();
        fifo_back_pressure();
        read_during_stream();
        finish_run();
    end

endmodule

// File: filelist.f
+incdir+.
sdmac_pkg.sv
scsi_sm.sv
dma_fifo.sv
scsi_data_path.sv
cpu_scsi_port.sv
scsi_dma_top.sv
tb_scsi_dma.sv
